// File: design/fetch_settings.svh
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// Datapath and address width
`define XLEN        32

// First fetch address out of reset
`define PC_RESET    32'h0000_0100

// addi x0, x0, 0 stands in for a faulting instruction
`define INSTR_NOP   32'h0000_0013

// Instruction memory word index width and depth
`define IMEM_AW     8
`define IMEM_DEPTH  (1 << `IMEM_AW)

// Translation config register select
`define CFG_AW      2

`endif

// File: design/fetch_pkg.sv
`include "fetch_settings.svh"

package fetch_pkg;

    typedef logic [`XLEN-1:0]    xlen_t;       // PC, vaddr, paddr, base, limit
    typedef logic [31:0]         instr_t;
    typedef logic [`IMEM_AW-1:0] imem_addr_t;  // Word index into instr_mem
    typedef logic [`CFG_AW-1:0]  cfg_addr_t;

    // Cause reported along with a fetched item
    typedef enum logic [3:0] {
        EXC_INSTR_MISALIGN     = 4'd0,
        EXC_INSTR_ACCESS_FAULT = 4'd1,
        EXC_NONE               = 4'd15   // Outside the cause range
    } exc_code_e;

    // Translation config register map
    typedef enum logic [`CFG_AW-1:0] {
        CFG_ENABLE = 0,
        CFG_BASE   = 1,
        CFG_LIMIT  = 2
    } cfg_reg_e;

endpackage : fetch_pkg

// File: design/addr_xlate.sv
`timescale 1ns/10ps

module addr_xlate (
    input  fetch_pkg::xlen_t vaddr_i,
    input  logic             xlate_en_i,
    input  fetch_pkg::xlen_t xlate_base_i,
    input  fetch_pkg::xlen_t xlate_limit_i,
    output fetch_pkg::xlen_t paddr_o,
    output logic             hit_o
);

    // Base/limit relocation, answered in the same cycle
    always_comb begin
        if (xlate_en_i) begin
            paddr_o = vaddr_i + xlate_base_i;      // Wraps modulo 2**XLEN
            hit_o   = (vaddr_i < xlate_limit_i);   // Limit is exclusive
        end else begin
            paddr_o = vaddr_i;                     // Identity map
            hit_o   = 1'b1;
        end
    end

endmodule : addr_xlate

// File: design/xlate_cfg_regs.sv
`timescale 1ns/10ps

module xlate_cfg_regs (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cfg_we_i,
    input  fetch_pkg::cfg_addr_t cfg_addr_i,
    input  fetch_pkg::xlen_t     cfg_wdata_i,
    output fetch_pkg::xlen_t     cfg_rdata_o,
    output logic                 xlate_en_o,
    output fetch_pkg::xlen_t     xlate_base_o,
    output fetch_pkg::xlen_t     xlate_limit_o
);
    import fetch_pkg::*;

    logic  en_q;
    xlen_t base_q;
    xlen_t limit_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            en_q    <= 1'b0;
            base_q  <= '0;
            limit_q <= '1;   // Whole space reachable until programmed
        end else if (cfg_we_i) begin
            case (cfg_addr_i)
                CFG_ENABLE: en_q    <= cfg_wdata_i[0];
                CFG_BASE:   base_q  <= cfg_wdata_i;
                CFG_LIMIT:  limit_q <= cfg_wdata_i;
                default:    ;
            endcase
        end
    end

    // Read back
    always_comb begin
        case (cfg_addr_i)
            CFG_ENABLE: cfg_rdata_o = xlen_t'(en_q);
            CFG_BASE:   cfg_rdata_o = base_q;
            CFG_LIMIT:  cfg_rdata_o = limit_q;
            default:    cfg_rdata_o = '0;
        endcase
    end

    assign xlate_en_o    = en_q;
    assign xlate_base_o  = base_q;
    assign xlate_limit_o = limit_q;

    // Software only writes mapped registers
    a_cfg_wr_mapped : assert property (@(posedge clk) disable iff (!rst_n)
        cfg_we_i |-> (cfg_addr_i inside {CFG_ENABLE, CFG_BASE, CFG_LIMIT}));

endmodule : xlate_cfg_regs

// File: design/instr_mem.sv
`timescale 1ns/10ps
`include "fetch_settings.svh"

module instr_mem (
    input  logic                  clk,
    input  logic                  rst_n,
    // Preload port
    input  logic                  load_we_i,
    input  fetch_pkg::imem_addr_t load_addr_i,
    input  fetch_pkg::instr_t     load_data_i,
    // Four-phase read port
    input  logic                  req_i,
    input  fetch_pkg::imem_addr_t addr_i,
    output logic                  ack_o,
    output fetch_pkg::instr_t     rdata_o
);
    import fetch_pkg::*;

    instr_t mem [`IMEM_DEPTH];
    logic   ack_q;
    instr_t rdata_q;

    always_ff @(posedge clk) begin
        if (load_we_i) begin
            mem[load_addr_i] <= load_data_i;
        end
    end

    // One read per transaction, ready when ack rises
    always_ff @(posedge clk) begin
        if (req_i && !ack_q) begin
            rdata_q <= mem[addr_i];
        end
    end

    // Ack trails req by one cycle in both directions
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req_i;
        end
    end

    assign ack_o   = ack_q;
    assign rdata_o = rdata_q;

    a_addr_stable : assert property (@(posedge clk) disable iff (!rst_n)
        req_i |=> (!req_i || $stable(addr_i)));

endmodule : instr_mem

// File: design/fetch_stage.sv
`timescale 1ns/10ps
`include "fetch_settings.svh"

module fetch_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    // Redirects
    input  logic                  exe_redirect_i,
    input  fetch_pkg::xlen_t      exe_pc_i,
    input  logic                  csr_redirect_i,
    input  fetch_pkg::xlen_t      csr_pc_i,
    // Translator
    output fetch_pkg::xlen_t      xlate_vaddr_o,
    input  fetch_pkg::xlen_t      xlate_paddr_i,
    input  logic                  xlate_hit_i,
    // Instruction memory, four-phase
    output logic                  imem_req_o,
    output fetch_pkg::imem_addr_t imem_addr_o,
    input  logic                  imem_ack_i,
    input  fetch_pkg::instr_t     imem_rdata_i,
    // Decode
    output logic                  id_valid_o,
    input  logic                  id_ready_i,
    output fetch_pkg::instr_t     id_instr_o,
    output fetch_pkg::xlen_t      id_pc_o,
    output logic                  id_exc_req_o,
    output fetch_pkg::exc_code_e  id_exc_code_o
);
    import fetch_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT_ACK_LOW,
        HOLD
    } fetch_state_e;

    fetch_state_e state_q;
    xlen_t        pc_q;
    xlen_t        pc_next;
    logic         req_q;
    imem_addr_t   addr_q;
    logic         discard_q;     // Word in flight is stale

    // Decode output register
    logic         valid_q;
    instr_t       instr_q;
    xlen_t        item_pc_q;
    logic         exc_req_q;
    exc_code_e    exc_code_q;

    logic         redirect;
    logic         transfer;
    logic         launch_req;
    logic         launch_exc;
    logic         capture;
    logic         item_kept;
    exc_code_e    exc_code;

    assign redirect  = exe_redirect_i | csr_redirect_i;
    assign transfer  = valid_q & id_ready_i;
    assign item_kept = valid_q & ~transfer & ~redirect;

    // Misalignment is checked ahead of the translation miss
    always_comb begin
        if (pc_q[1] | pc_q[0]) begin
            exc_code = EXC_INSTR_MISALIGN;
        end else if (!xlate_hit_i) begin
            exc_code = EXC_INSTR_ACCESS_FAULT;
        end else begin
            exc_code = EXC_NONE;
        end
    end

    assign launch_exc = (state_q == IDLE) && !redirect && (exc_code != EXC_NONE);
    assign launch_req = (state_q == IDLE) && !redirect && (exc_code == EXC_NONE);
    assign capture    = (state_q == REQ) && imem_ack_i && !discard_q && !redirect;

    // CSR target first, then execute, then step on transfer
    always_comb begin
        if (csr_redirect_i) begin
            pc_next = csr_pc_i;
        end else if (exe_redirect_i) begin
            pc_next = exe_pc_i;
        end else if (transfer) begin
            pc_next = pc_q + xlen_t'(4);
        end else begin
            pc_next = pc_q;   // Stalled
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= `PC_RESET;
        end else begin
            pc_q <= pc_next;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q   <= IDLE;
            req_q     <= 1'b0;
            discard_q <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (launch_exc) begin
                        state_q <= HOLD;    // No memory access on a fault
                    end else if (launch_req) begin
                        state_q <= REQ;
                        req_q   <= 1'b1;
                    end
                end
                REQ: begin
                    if (redirect) begin
                        discard_q <= 1'b1;
                    end
                    if (imem_ack_i) begin
                        state_q   <= WAIT_ACK_LOW;
                        req_q     <= 1'b0;
                        discard_q <= 1'b0;
                    end
                end
                WAIT_ACK_LOW: begin
                    if (!imem_ack_i) begin
                        state_q <= item_kept ? HOLD : IDLE;
                    end
                end
                HOLD: begin
                    if (redirect || transfer) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Word index latched with req and held through the transaction
    always_ff @(posedge clk) begin
        if (launch_req) begin
            addr_q <= xlate_paddr_i[`IMEM_AW+1:2];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q   <= 1'b0;
            exc_req_q <= 1'b0;
        end else if (redirect || transfer) begin
            valid_q   <= 1'b0;  // Redirect flushes a held item
            exc_req_q <= 1'b0;
        end else if (capture) begin
            valid_q   <= 1'b1;
            exc_req_q <= 1'b0;
        end else if (launch_exc) begin
            valid_q   <= 1'b1;
            exc_req_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            instr_q    <= imem_rdata_i;
            item_pc_q  <= pc_q;
            exc_code_q <= EXC_NONE;
        end else if (launch_exc) begin
            instr_q    <= `INSTR_NOP;
            item_pc_q  <= pc_q;
            exc_code_q <= exc_code;
        end
    end

    assign xlate_vaddr_o = pc_q;
    assign imem_req_o    = req_q;
    assign imem_addr_o   = addr_q;
    assign id_valid_o    = valid_q;
    assign id_instr_o    = instr_q;
    assign id_pc_o       = item_pc_q;
    assign id_exc_req_o  = exc_req_q;
    assign id_exc_code_o = exc_code_q;

    // A new req waits for ack to fall
    a_req_after_ack_low : assert property (@(posedge clk) disable iff (!rst_n)
        (!imem_req_o && imem_ack_i) |=> !imem_req_o);

    // A stalled item holds until decode takes it
    a_id_stable : assert property (@(posedge clk) disable iff (!rst_n)
        (id_valid_o && !id_ready_i && !redirect) |=>
            (id_valid_o && $stable(id_instr_o) && $stable(id_pc_o)
             && $stable(id_exc_req_o) && $stable(id_exc_code_o)));

endmodule : fetch_stage

// File: design/fetch_top.sv
`timescale 1ns/10ps

module fetch_top (
    input  logic                  clk,
    input  logic                  rst_n,
    // Redirects
    input  logic                  exe_redirect_i,
    input  fetch_pkg::xlen_t      exe_pc_i,
    input  logic                  csr_redirect_i,
    input  fetch_pkg::xlen_t      csr_pc_i,
    // Translation config
    input  logic                  cfg_we_i,
    input  fetch_pkg::cfg_addr_t  cfg_addr_i,
    input  fetch_pkg::xlen_t      cfg_wdata_i,
    output fetch_pkg::xlen_t      cfg_rdata_o,
    // Memory preload
    input  logic                  load_we_i,
    input  fetch_pkg::imem_addr_t load_addr_i,
    input  fetch_pkg::instr_t     load_data_i,
    // Decode
    output logic                  id_valid_o,
    input  logic                  id_ready_i,
    output fetch_pkg::instr_t     id_instr_o,
    output fetch_pkg::xlen_t      id_pc_o,
    output logic                  id_exc_req_o,
    output fetch_pkg::exc_code_e  id_exc_code_o
);
    import fetch_pkg::*;

    logic       xlate_en;
    xlen_t      xlate_base;
    xlen_t      xlate_limit;
    xlen_t      xlate_vaddr;
    xlen_t      xlate_paddr;
    logic       xlate_hit;

    logic       imem_req;
    imem_addr_t imem_addr;
    logic       imem_ack;
    instr_t     imem_rdata;

    xlate_cfg_regs u_cfg (
        .clk           (clk),
        .rst_n         (rst_n),
        .cfg_we_i      (cfg_we_i),
        .cfg_addr_i    (cfg_addr_i),
        .cfg_wdata_i   (cfg_wdata_i),
        .cfg_rdata_o   (cfg_rdata_o),
        .xlate_en_o    (xlate_en),
        .xlate_base_o  (xlate_base),
        .xlate_limit_o (xlate_limit)
    );

    addr_xlate u_xlate (
        .vaddr_i       (xlate_vaddr),
        .xlate_en_i    (xlate_en),
        .xlate_base_i  (xlate_base),
        .xlate_limit_i (xlate_limit),
        .paddr_o       (xlate_paddr),
        .hit_o         (xlate_hit)
    );

    fetch_stage u_fetch (
        .clk            (clk),
        .rst_n          (rst_n),
        .exe_redirect_i (exe_redirect_i),
        .exe_pc_i       (exe_pc_i),
        .csr_redirect_i (csr_redirect_i),
        .csr_pc_i       (csr_pc_i),
        .xlate_vaddr_o  (xlate_vaddr),
        .xlate_paddr_i  (xlate_paddr),
        .xlate_hit_i    (xlate_hit),
        .imem_req_o     (imem_req),
        .imem_addr_o    (imem_addr),
        .imem_ack_i     (imem_ack),
        .imem_rdata_i   (imem_rdata),
        .id_valid_o     (id_valid_o),
        .id_ready_i     (id_ready_i),
        .id_instr_o     (id_instr_o),
        .id_pc_o        (id_pc_o),
        .id_exc_req_o   (id_exc_req_o),
        .id_exc_code_o  (id_exc_code_o)
    );

    instr_mem u_imem (
        .clk         (clk),
        .rst_n       (rst_n),
        .load_we_i   (load_we_i),
        .load_addr_i (load_addr_i),
        .load_data_i (load_data_i),
        .req_i       (imem_req),
        .addr_i      (imem_addr),
        .ack_o       (imem_ack),
        .rdata_o     (imem_rdata)
    );

endmodule : fetch_top

// File: verif/fetch_tb.sv
`timescale 1ns/10ps
`include "fetch_settings.svh"

module fetch_tb;
    import fetch_pkg::*;

    localparam int TIMEOUT = 200;   // Cycles allowed for any one wait

    logic       clk;
    logic       rst_n;
    logic       exe_redirect;
    xlen_t      exe_pc;
    logic       csr_redirect;
    xlen_t      csr_pc;
    logic       cfg_we;
    cfg_addr_t  cfg_addr;
    xlen_t      cfg_wdata;
    xlen_t      cfg_rdata;
    logic       load_we;
    imem_addr_t load_addr;
    instr_t     load_data;
    logic       id_valid;
    logic       id_ready;
    instr_t     id_instr;
    xlen_t      id_pc;
    logic       id_exc_req;
    exc_code_e  id_exc_code;

    instr_t     model [`IMEM_DEPTH];   // Mirror of the memory contents
    logic       tb_en;                 // Expected translator state
    xlen_t      tb_base;
    xlen_t      tb_limit;
    integer     seed = 94639;

    // Last item taken by decode
    instr_t     got_instr;
    xlen_t      got_pc;
    logic       got_exc;
    exc_code_e  got_code;

    fetch_top DUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .exe_redirect_i (exe_redirect),
        .exe_pc_i       (exe_pc),
        .csr_redirect_i (csr_redirect),
        .csr_pc_i       (csr_pc),
        .cfg_we_i       (cfg_we),
        .cfg_addr_i     (cfg_addr),
        .cfg_wdata_i    (cfg_wdata),
        .cfg_rdata_o    (cfg_rdata),
        .load_we_i      (load_we),
        .load_addr_i    (load_addr),
        .load_data_i    (load_data),
        .id_valid_o     (id_valid),
        .id_ready_i     (id_ready),
        .id_instr_o     (id_instr),
        .id_pc_o        (id_pc),
        .id_exc_req_o   (id_exc_req),
        .id_exc_code_o  (id_exc_code)
    );

    always #5 clk = ~clk;

    task automatic abort_run();
        $display("Test FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_instr(input string name, input instr_t got, input instr_t exp);
        if (got !== exp) begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_xlen(input string name, input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_exc(input string name, input exc_code_e got, input exc_code_e exp);
        if (got !== exp) begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    // Called at time zero or just after a rising edge
    task automatic apply_reset();
        rst_n        <= 1'b0;
        id_ready     <= 1'b0;
        exe_redirect <= 1'b0;
        csr_redirect <= 1'b0;
        cfg_we       <= 1'b0;
        load_we      <= 1'b0;
        tb_en    = 1'b0;
        tb_base  = '0;
        tb_limit = '1;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    task automatic preload_memory();
        instr_t word;
        for (int i = 0; i < `IMEM_DEPTH; i++) begin
            word     = $random(seed);
            model[i] = word;
            @(posedge clk);
            load_we   <= 1'b1;
            load_addr <= imem_addr_t'(i);
            load_data <= word;
        end
        @(posedge clk);
        load_we <= 1'b0;
    endtask

    // Returns on the edge that completes the transfer
    task automatic wait_item();
        int n;
        n = 0;
        @(negedge clk);
        while (!(id_valid && id_ready) && n <= TIMEOUT) begin
            n++;
            @(negedge clk);
        end
        if (n > TIMEOUT) begin
            $display("Timeout: no item reached decode within %0d cycles", TIMEOUT);
            abort_run();
        end else begin
            got_instr = id_instr;
            got_pc    = id_pc;
            got_exc   = id_exc_req;
            got_code  = id_exc_code;
            @(posedge clk);
        end
    endtask

    task automatic wait_valid();
        int n;
        n = 0;
        @(negedge clk);
        while (!id_valid && n <= TIMEOUT) begin
            n++;
            @(negedge clk);
        end
        if (n > TIMEOUT) begin
            $display("Timeout: fetch offered no item within %0d cycles", TIMEOUT);
            abort_run();
        end
    endtask

    task automatic wait_imem_req();
        int n;
        n = 0;
        @(negedge clk);
        while (!DUT.imem_req && n <= TIMEOUT) begin
            n++;
            @(negedge clk);
        end
        if (n > TIMEOUT) begin
            $display("Timeout: fetch started no memory read within %0d cycles", TIMEOUT);
            abort_run();
        end
    endtask

    // Ready is low in the redirect cycle so nothing transfers there
    task automatic pulse_redirect(input logic exe_v, input xlen_t exe_t,
                                  input logic csr_v, input xlen_t csr_t);
        @(posedge clk);
        id_ready     <= 1'b0;
        exe_redirect <= exe_v;
        exe_pc       <= exe_t;
        csr_redirect <= csr_v;
        csr_pc       <= csr_t;
        @(posedge clk);
        exe_redirect <= 1'b0;
        csr_redirect <= 1'b0;
        id_ready     <= 1'b1;
    endtask

    task automatic write_cfg(input cfg_addr_t addr, input xlen_t data);
        @(posedge clk);
        cfg_we    <= 1'b1;
        cfg_addr  <= addr;
        cfg_wdata <= data;
        @(posedge clk);
        cfg_we <= 1'b0;
        case (addr)
            CFG_ENABLE: tb_en    = data[0];
            CFG_BASE:   tb_base  = data;
            CFG_LIMIT:  tb_limit = data;
            default:    ;
        endcase
    endtask

    task automatic read_cfg(input cfg_addr_t addr, output xlen_t data);
        @(posedge clk);
        cfg_addr <= addr;
        @(negedge clk);
        data = cfg_rdata;
    endtask

    // Expected item from the alignment, limit and base rules
    task automatic check_item(input xlen_t exp_pc);
        xlen_t     paddr;
        instr_t    exp_instr;
        logic      exp_exc;
        exc_code_e exp_code;
        paddr = tb_en ? exp_pc + tb_base : exp_pc;
        if (exp_pc[1:0] != 2'b00) begin
            exp_exc   = 1'b1;
            exp_code  = EXC_INSTR_MISALIGN;
            exp_instr = `INSTR_NOP;
        end else if (tb_en && exp_pc >= tb_limit) begin
            exp_exc   = 1'b1;
            exp_code  = EXC_INSTR_ACCESS_FAULT;
            exp_instr = `INSTR_NOP;
        end else begin
            exp_exc   = 1'b0;
            exp_code  = EXC_NONE;
            exp_instr = model[paddr[`IMEM_AW+1:2]];
        end
        check_xlen("id_pc_o", got_pc, exp_pc);
        check_flag("id_exc_req_o", got_exc, exp_exc);
        check_exc("id_exc_code_o", got_code, exp_code);
        check_instr("id_instr_o", got_instr, exp_instr);
    endtask

    task automatic test_sequential();
        xlen_t pc;
        apply_reset();
        id_ready <= 1'b1;
        @(negedge clk);
        check_flag("imem_req", DUT.imem_req, 1'b0);   // Reset values
        check_flag("id_valid_o", id_valid, 1'b0);
        check_flag("id_exc_req_o", id_exc_req, 1'b0);
        pc = `PC_RESET;
        repeat (8) begin
            wait_item();
            check_item(pc);
            pc = pc + 32'd4;
        end
    endtask

    task automatic test_backpressure();
        xlen_t     pc;
        int        stall;
        instr_t    snap_instr;
        xlen_t     snap_pc;
        logic      snap_exc;
        exc_code_e snap_code;
        apply_reset();
        pc = `PC_RESET;
        repeat (10) begin
            stall = {$random(seed)} % 6;
            wait_valid();
            snap_instr = id_instr;
            snap_pc    = id_pc;
            snap_exc   = id_exc_req;
            snap_code  = id_exc_code;
            repeat (stall) begin
                @(negedge clk);
                check_flag("id_valid_o", id_valid, 1'b1);
                check_instr("id_instr_o", id_instr, snap_instr);
                check_xlen("id_pc_o", id_pc, snap_pc);
                check_flag("id_exc_req_o", id_exc_req, snap_exc);
                check_exc("id_exc_code_o", id_exc_code, snap_code);
            end
            @(posedge clk);
            id_ready <= 1'b1;
            wait_item();
            id_ready <= 1'b0;
            check_instr("id_instr_o", got_instr, snap_instr);
            check_item(pc);
            pc = pc + 32'd4;
        end
    endtask

    task automatic test_redirect();
        apply_reset();
        id_ready <= 1'b1;
        wait_item();
        check_item(`PC_RESET);
        pulse_redirect(1'b1, 32'h0000_0240, 1'b0, '0);
        wait_item();
        check_item(32'h0000_0240);
        wait_item();
        check_item(32'h0000_0244);
        pulse_redirect(1'b1, 32'h0000_0080, 1'b1, 32'h0000_0380);   // CSR wins
        wait_item();
        check_item(32'h0000_0380);
        wait_imem_req();                                         // Read of 0x384 in flight
        pulse_redirect(1'b1, 32'h0000_0020, 1'b0, '0);
        wait_item();
        check_item(32'h0000_0020);
    endtask

    task automatic test_misaligned();
        apply_reset();
        id_ready <= 1'b1;
        pulse_redirect(1'b1, 32'h0000_0202, 1'b0, '0);
        wait_item();
        check_item(32'h0000_0202);
        wait_item();
        check_item(32'h0000_0206);
        pulse_redirect(1'b1, 32'h0000_0300, 1'b0, '0);
        wait_item();
        check_item(32'h0000_0300);
        wait_item();
        check_item(32'h0000_0304);
    endtask

    task automatic test_translation();
        xlen_t rd;
        apply_reset();
        write_cfg(CFG_BASE, 32'h0000_0040);
        write_cfg(CFG_LIMIT, 32'h0000_0200);
        write_cfg(CFG_ENABLE, 32'h0000_0001);
        read_cfg(CFG_ENABLE, rd);
        check_xlen("cfg_rdata_o", rd, xlen_t'(tb_en));
        read_cfg(CFG_BASE, rd);
        check_xlen("cfg_rdata_o", rd, tb_base);
        read_cfg(CFG_LIMIT, rd);
        check_xlen("cfg_rdata_o", rd, tb_limit);
        pulse_redirect(1'b1, 32'h0000_0100, 1'b0, '0);
        wait_item();
        check_item(32'h0000_0100);
        wait_item();
        check_item(32'h0000_0104);
        pulse_redirect(1'b1, 32'h0000_01f8, 1'b0, '0);   // Walk across the limit
        wait_item();
        check_item(32'h0000_01f8);
        wait_item();
        check_item(32'h0000_01fc);
        wait_item();
        check_item(32'h0000_0200);
        wait_item();
        check_item(32'h0000_0204);
    endtask

    initial begin
        clk       = 1'b0;
        exe_pc    <= '0;
        csr_pc    <= '0;
        cfg_addr  <= '0;
        cfg_wdata <= '0;
        load_addr <= '0;
        load_data <= '0;
        apply_reset();
        preload_memory();
        test_sequential();
        test_backpressure();
        test_redirect();
        test_misaligned();
        test_translation();
        $display("Test OK");
        $finish;
    end

endmodule : fetch_tb

// File: project.f
+incdir+design
design/fetch_pkg.sv
design/addr_xlate.sv
design/xlate_cfg_regs.sv
design/instr_mem.sv
design/fetch_stage.sv
design/fetch_top.sv
verif/fetch_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/10ps -j 0
TOP       = fetch_tb
FILELIST  = project.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(OBJDIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR) -o V$(TOP)
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "^Test OK$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
